// File: logic/mem_router_params.svh
`ifndef MEM_ROUTER_PARAMS_SVH
`define MEM_ROUTER_PARAMS_SVH

//////////////////////////////////////////////////
// Data port widths
//////////////////////////////////////////////////

`define MR_ADDR_W 32
`define MR_DATA_W 32
`define MR_STRB_W 4

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////

// Single word that leaves the chip as a write strobe
`define MR_EXIT_ADDR 32'h00010150
// Everything from here up is peripheral space
`define MR_PERI_BASE 32'h10000000

`endif

// File: logic/mem_router_pkg.sv
`include "mem_router_params.svh"

package mem_router_pkg;

    // Data cache command in the pipeline's own encoding
    typedef enum logic [1:0]
    {
        ctrl_idle  = 2'd0,
        ctrl_read  = 2'd1,
        ctrl_write = 2'd2,
        ctrl_flush = 2'd3
    } mem_ctrl_e;

    // Where a data request ends up
    typedef enum logic [1:0]
    {
        region_cache = 2'd0,
        region_exit  = 2'd1,
        region_peri  = 2'd2
    } region_e;

    // Request from the pipeline data port
    typedef struct packed
    {
        mem_ctrl_e               ctrl;
        logic [`MR_ADDR_W-1:0]   addr;
        logic [`MR_DATA_W-1:0]   wdata;
        logic [`MR_STRB_W-1:0]   byte_en;
    } proc_req_t;

    // Request towards the peripheral block
    typedef struct packed
    {
        logic                    write;
        logic [`MR_ADDR_W-1:0]   addr;
        logic [`MR_DATA_W-1:0]   wdata;
        logic [`MR_STRB_W-1:0]   strb;
    } peri_req_t;

endpackage

// File: logic/data_port_decode.sv
`timescale 1ns/10ps
`include "mem_router_params.svh"

module data_port_decode
(
    input  logic                        CLK,
    input  logic                        rst_n,
    input  mem_router_pkg::proc_req_t   proc_req,
    input  logic                        cache_ready,
    input  logic                        ins_ready,
    input  logic                        run_enable,
    output mem_router_pkg::region_e     region,
    output mem_router_pkg::proc_req_t   cache_req,
    output logic                        exit_wr_en,
    output logic [`MR_DATA_W-1:0]       exit_wr_data
);

    logic exit_go;

    //////////////////////////////////////////////////
    // Region decode
    //////////////////////////////////////////////////

    // Exit word sits below the peripheral base, so test it first
    always_comb
    begin
        if (proc_req.addr == `MR_EXIT_ADDR)
        begin
            region = mem_router_pkg::region_exit;
        end
        else if (proc_req.addr >= `MR_PERI_BASE)
        begin
            region = mem_router_pkg::region_peri;
        end
        else
        begin
            region = mem_router_pkg::region_cache;
        end
    end

    // Cache sees the request untouched but only acts on its own region
    always_comb
    begin
        cache_req = proc_req;
        if (region != mem_router_pkg::region_cache)
        begin
            cache_req.ctrl = mem_router_pkg::ctrl_idle;
        end
    end

    //////////////////////////////////////////////////
    // Exit port
    //////////////////////////////////////////////////

    // Only writes count, and only once the whole front end is ready
    assign exit_go = (region == mem_router_pkg::region_exit)
                  && (proc_req.ctrl == mem_router_pkg::ctrl_write)
                  && cache_ready && ins_ready && run_enable;

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            exit_wr_en <= 1'b0;
        end
        else
        begin
            exit_wr_en <= exit_go;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (exit_go)
        begin
            exit_wr_data <= proc_req.wdata;
        end
    end

endmodule

// File: logic/peri_sequencer.sv
`timescale 1ns/10ps
`include "mem_router_params.svh"

module peri_sequencer
(
    input  logic                        CLK,
    input  logic                        rst_n,
    input  mem_router_pkg::proc_req_t   proc_req,
    input  mem_router_pkg::region_e     region,
    input  logic                        cache_ready,
    input  logic                        ins_ready,
    input  logic [`MR_DATA_W-1:0]       cache_rdata,
    input  logic                        run_enable,
    input  logic                        peri_done,
    input  logic [`MR_DATA_W-1:0]       peri_rdata,
    output logic                        peri_start,
    output mem_router_pkg::peri_req_t   peri_req,
    output logic                        fetch_enable,
    output logic                        data_ready,
    output logic [`MR_DATA_W-1:0]       proc_rdata
);

    typedef enum logic [1:0]
    {
        st_idle    = 2'd0,
        st_issue   = 2'd1,
        st_wait    = 2'd2,
        st_respond = 2'd3
    } seq_state_e;

    seq_state_e              state;
    seq_state_e              state_nxt;
    logic                    peri_cmd;
    logic                    accept;
    logic [`MR_DATA_W-1:0]   peri_rdata_q;

    //////////////////////////////////////////////////
    // Acceptance
    //////////////////////////////////////////////////

    // A live command aimed at peripheral space
    assign peri_cmd = (region == mem_router_pkg::region_peri)
                   && (proc_req.ctrl != mem_router_pkg::ctrl_idle);

    // One access at a time, and both caches must be quiet
    assign accept = (state == st_idle) && peri_cmd && cache_ready && ins_ready;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (accept)
                begin
                    state_nxt = st_issue;
                end
            end
            st_issue:
            begin
                state_nxt = st_wait;
            end
            st_wait:
            begin
                // Latency is whatever the peripheral needs
                if (peri_done)
                begin
                    state_nxt = st_respond;
                end
            end
            default:
            begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Request is frozen for the whole access
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            peri_req.write <= (proc_req.ctrl == mem_router_pkg::ctrl_write);
            peri_req.addr  <= proc_req.addr;
            peri_req.wdata <= proc_req.wdata;
            peri_req.strb  <= proc_req.byte_en;
        end
    end

    // Read data only valid alongside the done pulse
    always_ff @(posedge CLK)
    begin
        if ((state == st_wait) && peri_done)
        begin
            peri_rdata_q <= peri_rdata;
        end
    end

    //////////////////////////////////////////////////
    // Outputs to peripheral and pipeline
    //////////////////////////////////////////////////

    assign peri_start = (state == st_issue);

    // Fetch stalls from the accepting edge until the response is out
    assign fetch_enable = ins_ready && run_enable && (state == st_idle) && !accept;

    always_comb
    begin
        data_ready = 1'b0;
        proc_rdata = cache_rdata;
        if (state == st_respond)
        begin
            data_ready = 1'b1;
            proc_rdata = peri_rdata_q;
        end
        else if (state == st_idle)
        begin
            // Peripheral command still waiting holds the data port
            data_ready = cache_ready && !peri_cmd;
        end
    end

endmodule

// File: logic/mem_router_top.sv
`timescale 1ns/10ps
`include "mem_router_params.svh"

module mem_router_top
(
    input  logic                        CLK,
    input  logic                        rst_n,

    // Pipeline data port
    input  mem_router_pkg::proc_req_t   proc_req,
    output logic                        data_ready,
    output logic [`MR_DATA_W-1:0]       proc_rdata,

    // Data cache
    output mem_router_pkg::proc_req_t   cache_req,
    input  logic                        cache_ready,
    input  logic [`MR_DATA_W-1:0]       cache_rdata,

    // Instruction side
    input  logic                        ins_ready,
    input  logic                        run_enable,
    output logic                        fetch_enable,

    // Exit port
    output logic                        exit_wr_en,
    output logic [`MR_DATA_W-1:0]       exit_wr_data,

    // Peripheral
    output logic                        peri_start,
    output mem_router_pkg::peri_req_t   peri_req,
    input  logic                        peri_done,
    input  logic [`MR_DATA_W-1:0]       peri_rdata
);

    mem_router_pkg::region_e region;

    //////////////////////////////////////////////////
    // Address decode and exit strobe
    //////////////////////////////////////////////////

    data_port_decode u_decode
    (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .proc_req     (proc_req),
        .cache_ready  (cache_ready),
        .ins_ready    (ins_ready),
        .run_enable   (run_enable),
        .region       (region),
        .cache_req    (cache_req),
        .exit_wr_en   (exit_wr_en),
        .exit_wr_data (exit_wr_data)
    );

    //////////////////////////////////////////////////
    // Peripheral access and stalls
    //////////////////////////////////////////////////

    peri_sequencer u_sequencer
    (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .proc_req     (proc_req),
        .region       (region),
        .cache_ready  (cache_ready),
        .ins_ready    (ins_ready),
        .cache_rdata  (cache_rdata),
        .run_enable   (run_enable),
        .peri_done    (peri_done),
        .peri_rdata   (peri_rdata),
        .peri_start   (peri_start),
        .peri_req     (peri_req),
        .fetch_enable (fetch_enable),
        .data_ready   (data_ready),
        .proc_rdata   (proc_rdata)
    );

endmodule

// File: bench/mem_router_asserts.sv
`timescale 1ns/10ps

module mem_router_asserts
(
    input  logic                        CLK,
    input  logic                        rst_n,
    input  mem_router_pkg::proc_req_t   proc_req,
    input  logic                        exit_wr_en,
    input  logic                        peri_start,
    input  logic                        fetch_enable
);

    int unsigned err_cnt = 0;

    // Start is a single-cycle pulse
    a_start_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
        peri_start |=> !peri_start)
    else
    begin
        err_cnt++;
        $error("peri_start high for two cycles in a row");
    end

    // Two strobes in a row must come from two different requests
    a_exit_once: assert property (@(posedge CLK) disable iff (!rst_n)
        (exit_wr_en && $past(exit_wr_en)) |-> ($past(proc_req) != $past(proc_req, 2)))
    else
    begin
        err_cnt++;
        $error("exit_wr_en strobed twice for one held request");
    end

    // Fetch is stalled from the accepting cycle through the start pulse
    a_fetch_stall: assert property (@(posedge CLK) disable iff (!rst_n)
        peri_start |-> !fetch_enable && !$past(fetch_enable))
    else
    begin
        err_cnt++;
        $error("fetch_enable high during acceptance or peri_start");
    end

endmodule

bind mem_router_top mem_router_asserts u_asserts (.*);

// File: bench/mem_router_tb.sv
`timescale 1ns/10ps
`include "mem_router_params.svh"

module mem_router_tb;

    localparam mem_router_pkg::mem_ctrl_e cmd_idle = mem_router_pkg::ctrl_idle;
    localparam mem_router_pkg::mem_ctrl_e cmd_rd   = mem_router_pkg::ctrl_read;
    localparam mem_router_pkg::mem_ctrl_e cmd_wr   = mem_router_pkg::ctrl_write;
    localparam mem_router_pkg::mem_ctrl_e cmd_fl   = mem_router_pkg::ctrl_flush;
    localparam mem_router_pkg::region_e   to_cache = mem_router_pkg::region_cache;
    localparam mem_router_pkg::region_e   to_exit  = mem_router_pkg::region_exit;
    localparam mem_router_pkg::region_e   to_peri  = mem_router_pkg::region_peri;
    localparam int num_rows    = 15;
    localparam int max_delay   = 8;
    localparam int cycle_limit = num_rows * (max_delay + 6) + 20;

    // Ready bits are cache_ready, ins_ready, run_enable
    // Delay 0 means a random latency
    typedef struct packed
    {
        mem_router_pkg::proc_req_t  req;
        logic [2:0]                 rdy;
        logic [3:0]                 delay;
        mem_router_pkg::region_e    outcome;
    } row_t;

    row_t rows [num_rows] = '{
        '{'{cmd_rd,   32'h0000_0100, 32'h0000_0000, 4'hf}, 3'b111, 4'd0, to_cache},
        '{'{cmd_wr,   32'h0000_0204, 32'ha5a5_0001, 4'h3}, 3'b111, 4'd0, to_cache},
        '{'{cmd_fl,   32'h0000_0300, 32'h0000_0000, 4'hf}, 3'b111, 4'd0, to_cache},
        '{'{cmd_rd,   32'h0001_014c, 32'h0000_0000, 4'hf}, 3'b011, 4'd0, to_cache},
        '{'{cmd_wr,   32'h1000_0010, 32'h1234_5678, 4'h3}, 3'b111, 4'd2, to_peri},
        '{'{cmd_rd,   32'h1000_0020, 32'h0000_0000, 4'hf}, 3'b111, 4'd0, to_peri},
        '{'{cmd_rd,   32'hffff_fff0, 32'h0000_0000, 4'hf}, 3'b111, 4'd8, to_peri},
        '{'{cmd_wr,   `MR_EXIT_ADDR, 32'hcafe_0001, 4'hf}, 3'b111, 4'd0, to_exit},
        '{'{cmd_wr,   `MR_EXIT_ADDR, 32'hcafe_0002, 4'hf}, 3'b011, 4'd0, to_exit},
        '{'{cmd_rd,   `MR_EXIT_ADDR, 32'h0000_0000, 4'hf}, 3'b111, 4'd0, to_exit},
        '{'{cmd_wr,   `MR_EXIT_ADDR, 32'hcafe_0003, 4'hf}, 3'b110, 4'd0, to_exit},
        '{'{cmd_rd,   32'h0000_0400, 32'h0000_0000, 4'hf}, 3'b101, 4'd0, to_cache},
        '{'{cmd_idle, 32'h1000_0040, 32'hdead_beef, 4'hf}, 3'b111, 4'd0, to_peri},
        '{'{cmd_wr,   32'h1000_0050, 32'h0bad_f00d, 4'h1}, 3'b011, 4'd0, to_peri},
        '{'{cmd_fl,   32'h0fff_fffc, 32'h0000_0000, 4'hf}, 3'b111, 4'd0, to_cache}
    };

    logic                        CLK;
    logic                        rst_n;
    mem_router_pkg::proc_req_t   proc_req;
    logic                        cache_ready;
    logic                        ins_ready;
    logic                        run_enable;
    logic                        peri_done;
    logic [`MR_DATA_W-1:0]       cache_rdata;
    logic [`MR_DATA_W-1:0]       peri_rdata;
    logic                        data_ready;
    logic [`MR_DATA_W-1:0]       proc_rdata;
    mem_router_pkg::proc_req_t   cache_req;
    logic                        fetch_enable;
    logic                        exit_wr_en;
    logic [`MR_DATA_W-1:0]       exit_wr_data;
    logic                        peri_start;
    mem_router_pkg::peri_req_t   peri_req;
    logic [15:0]                 lfsr;
    int                          cycle_cnt;

    mem_router_top UUT (.*);

    always #50 CLK = ~CLK;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input logic [`MR_DATA_W-1:0] exp,
                              input logic [`MR_DATA_W-1:0] act);
        if (act !== exp)
            fail_now($sformatf("error %0d ns %s: expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_req(input string name, input mem_router_pkg::proc_req_t exp,
                             input mem_router_pkg::proc_req_t act);
        if (act !== exp)
            fail_now($sformatf("error %0d ns %s: expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_peri(input string name, input mem_router_pkg::peri_req_t exp,
                              input mem_router_pkg::peri_req_t act);
        if (act !== exp)
            fail_now($sformatf("error %0d ns %s: expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_now($sformatf("error %0d ns %s: expected %b, got %b", $time, name, exp, act));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [`MR_DATA_W-1:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            val  = {val[`MR_DATA_W-2:0], lfsr[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // One table row entered and left on a falling edge
    //////////////////////////////////////////////////

    task automatic run_row(input row_t r);
        mem_router_pkg::proc_req_t  exp_cache;
        mem_router_pkg::peri_req_t  exp_peri;
        logic [`MR_DATA_W-1:0]      word;
        logic                       peri_cmd;
        logic                       accepted;
        logic                       strobe;
        int                         dly;

        peri_cmd  = (r.outcome == to_peri) && (r.req.ctrl != cmd_idle);
        accepted  = peri_cmd && r.rdy[2] && r.rdy[1];
        strobe    = (r.outcome == to_exit) && (r.req.ctrl == cmd_wr) && (&r.rdy);
        exp_cache = r.req;
        if (r.outcome != to_cache)
            exp_cache.ctrl = cmd_idle;
        exp_peri = '{r.req.ctrl == cmd_wr, r.req.addr, r.req.wdata, r.req.byte_en};

        proc_req    = r.req;
        cache_ready = r.rdy[2];
        ins_ready   = r.rdy[1];
        run_enable  = r.rdy[0];
        take_bits(`MR_DATA_W, word);
        cache_rdata = word;
        #1;
        check_req("cache_req", exp_cache, cache_req);
        check_bit("fetch_enable", r.rdy[1] && r.rdy[0] && !accepted, fetch_enable);
        check_bit("data_ready", r.rdy[2] && !peri_cmd, data_ready);
        if (!peri_cmd)
            check_word("proc_rdata", word, proc_rdata);

        @(negedge CLK);
        check_bit("exit_wr_en", strobe, exit_wr_en);
        check_bit("peri_start", accepted, peri_start);
        if (strobe)
            check_word("exit_wr_data", r.req.wdata, exit_wr_data);
        if (accepted)
        begin
            dly = r.delay;
            if (dly == 0)
            begin
                take_bits(3, word);
                dly = word + 1;
            end
            // Peripheral latency counts from the start pulse
            for (int k = 0; k <= dly; k++)
            begin
                if (k > 0)
                    @(negedge CLK);
                check_bit("peri_start", k == 0, peri_start);
                check_bit("data_ready", 1'b0, data_ready);
                check_bit("fetch_enable", 1'b0, fetch_enable);
                check_req("cache_req", exp_cache, cache_req);
                check_peri("peri_req", exp_peri, peri_req);
            end
            take_bits(`MR_DATA_W, word);
            peri_done  = 1'b1;
            peri_rdata = word;
            @(negedge CLK);
            peri_done  = 1'b0;
            peri_rdata = ~word;
            check_bit("data_ready", 1'b1, data_ready);
            check_bit("fetch_enable", 1'b0, fetch_enable);
            check_word("proc_rdata", word, proc_rdata);
        end

        // Pipeline has its answer and moves on
        proc_req = '0;
        @(negedge CLK);
        check_bit("exit_wr_en", 1'b0, exit_wr_en);
        check_bit("peri_start", 1'b0, peri_start);
        check_bit("fetch_enable", r.rdy[1] && r.rdy[0], fetch_enable);
        check_bit("data_ready", r.rdy[2], data_ready);
    endtask

    // Watchdog that also stops on a failed bound assertion
    always @(posedge CLK)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
            fail_now($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
        else if (UUT.u_asserts.err_cnt != 0)
            fail_now("a bound assertion on the DUT failed");
    end

    initial
    begin
        CLK         = 1'b0;
        rst_n       = 1'b0;
        proc_req    = '0;
        cache_ready = 1'b0;
        ins_ready   = 1'b0;
        run_enable  = 1'b0;
        peri_done   = 1'b0;
        cache_rdata = '0;
        peri_rdata  = '0;
        lfsr        = 16'd30632;
        cycle_cnt   = 0;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        @(negedge CLK);
        check_bit("peri_start", 1'b0, peri_start);
        check_bit("exit_wr_en", 1'b0, exit_wr_en);
        check_bit("fetch_enable", 1'b0, fetch_enable);
        for (int i = 0; i < num_rows; i++)
            run_row(rows[i]);
        if (UUT.u_asserts.err_cnt != 0)
            fail_now("a bound assertion on the DUT failed");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// File: compile.f
+incdir+logic
logic/mem_router_pkg.sv
logic/data_port_decode.sv
logic/peri_sequencer.sv
logic/mem_router_top.sv
bench/mem_router_asserts.sv
bench/mem_router_tb.sv
